//--- compile.f
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_bus_if.sv
hdl/alu_lane.sv
hdl/cdb_arbiter.sv
hdl/res_station.sv
hdl/exec_core.sv
verification/exec_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exec_core_tb
FILELIST  := compile.f
LOG       := sim.log

SIM  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/exec_core_tb.sv
/* execution slice testbench */
`timescale 1ns/10ps
`default_nettype none
`include "exec_macros.svh"

module exec_core_tb import exec_pkg::*;;

  localparam int NTAGS   = 1 << `ROB_TAG_W;
  // cycle budget per test with reset and margin added on top
  localparam int T1_LEN  = 80;
  localparam int T2_LEN  = 160;
  localparam int T3_LEN  = 60;
  localparam int T4_LEN  = 80;
  localparam int T5_LEN  = 80;
  localparam int TIMEOUT = 16 + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + 200;

  // one in-flight op as the model sees it
  typedef struct packed {
    alu_op_e          op;
    logic [`XLEN-1:0] v1;
    logic [`XLEN-1:0] v2;
    logic             r1;       // operand value known
    logic             r2;
    int               w1;       // source tag or -1 for an immediate
    int               w2;
  } track_t;

  logic                  clk_in;
  logic                  rst_in;
  logic                  rdy_in;
  logic                  flush_in;
  logic                  issue_valid;
  alu_op_e               issue_op;
  operand_t              issue_src1;
  operand_t              issue_src2;
  logic [`ROB_TAG_W-1:0] issue_dest;
  logic                  rs_full;
  logic                  cdb_valid;
  logic [`ROB_TAG_W-1:0] cdb_tag;
  logic [`XLEN-1:0]      cdb_value;

  track_t           pend [int];      // in flight keyed by tag
  logic [`XLEN-1:0] done_val [int];  // last modeled result per tag
  bit               stale [int];     // dropped by a flush
  int               seed    = 32'h4e20_c59b;
  int               tag_ptr = 0;
  int               errors  = 0;
  int               checks  = 0;
  int               tests   = 0;
  int               mark    = 0;
  int               cycles  = 0;

  exec_core UUT (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .flush_in    (flush_in),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_src1  (issue_src1),
    .issue_src2  (issue_src2),
    .issue_dest  (issue_dest),
    .rs_full     (rs_full),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_value   (cdb_value)
  );

  always #2 clk_in = ~clk_in;

  // rv32i alu rules with 5 bit shift amounts
  function automatic logic [`XLEN-1:0] alu_model(alu_op_e op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);  // sign fill
      ALU_SLT:  return (a[`XLEN-1] != b[`XLEN-1]) ? `XLEN'(a[`XLEN-1]) : `XLEN'(a < b);
      ALU_SLTU: return `XLEN'(a < b);
      default:  return '0;
    endcase
  endfunction

  function automatic alu_op_e random_op();
    int r;
    r = $unsigned($random(seed)) % 10;
    return alu_op_e'(4'(r));
  endfunction

  // rotate through tags and skip ones still in flight
  function automatic int next_free_tag();
    int t;
    do
    begin
      t = tag_ptr;
      tag_ptr = (tag_ptr + 1) % NTAGS;
    end
    while (pend.exists(t));
    done_val.delete(t);       // new instance has no result yet
    return t;
  endfunction

  // value if known or else wait on the source tag
  function automatic operand_t src_operand(int p, logic [`XLEN-1:0] a);
    operand_t o;
    o.tag = (p < 0) ? '0 : `ROB_TAG_W'(p);
    if (p < 0)
    begin
      o.value = a;
      o.ready = 1'b1;
    end
    else if (done_val.exists(p))
    begin
      o.value = done_val[p];
      o.ready = 1'b1;
    end
    else
    begin
      o.value = $random(seed);  // junk that must not be used
      o.ready = 1'b0;
    end
    return o;
  endfunction

  task automatic step();
    @(posedge clk_in);
    #0.5;
  endtask

  task automatic send_op(input alu_op_e op, input int p1, input int p2,
                         input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b, input int dest);
    operand_t s1;
    operand_t s2;
    track_t   m;
    while (rs_full)
      step();
    s1 = src_operand(p1, a);
    s2 = src_operand(p2, b);
    m.op = op;
    m.v1 = s1.value;
    m.v2 = s2.value;
    m.r1 = s1.ready;
    m.r2 = s2.ready;
    m.w1 = p1;
    m.w2 = p2;
    pend[dest] = m;
    stale.delete(dest);
    issue_valid = 1'b1;
    issue_op    = op;
    issue_src1  = s1;
    issue_src2  = s2;
    issue_dest  = `ROB_TAG_W'(dest);
    step();
    issue_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (pend.size() != 0)
      step();
    repeat (3) step();        // room for a duplicate broadcast to show up
  endtask

  task automatic pulse_flush();
    foreach (pend[k])
      stale[k] = 1'b1;
    pend.delete();
    flush_in = 1'b1;
    step();
    flush_in = 1'b0;
  endtask

  task automatic close_test(input int num, input string name);
    tests++;
    $display("test %0d %s done, %0d errors", num, name, errors - mark);
    mark = errors;
  endtask

  // scoreboard samples the cdb mid-cycle where it is stable
  always @(negedge clk_in)
  begin
    int               t;
    track_t           m;
    logic [`XLEN-1:0] want;
    if (!rst_in && cdb_valid)
    begin
      t = int'(cdb_tag);
      checks++;
      a_not_stale: assert (!stale.exists(t))
      else
      begin
        errors++;
        $display("tag %0d was broadcast after a flush dropped it", t);
      end
      a_in_flight: assert (pend.exists(t))
      else
      begin
        errors++;
        $display("tag %0d was broadcast but is not in flight", t);
      end
      if (pend.exists(t))
      begin
        m = pend[t];
        a_src_first: assert (m.r1 && m.r2)
        else
        begin
          errors++;
          $display("tag %0d completed before its source tag", t);
        end
        want = alu_model(m.op, m.v1, m.v2);
        a_value: assert (cdb_value === want)
        else
        begin
          errors++;
          $display("[FAIL] cdb_value %h expected %h cdb_tag %h", cdb_value, want, cdb_tag);
        end
        done_val[t] = want;
        pend.delete(t);
        foreach (pend[k])          // wake consumers of this tag
        begin
          if (!pend[k].r1 && pend[k].w1 == t)
          begin
            pend[k].v1 = want;
            pend[k].r1 = 1'b1;
          end
          if (!pend[k].r2 && pend[k].w2 == t)
          begin
            pend[k].v2 = want;
            pend[k].r2 = 1'b1;
          end
        end
      end
    end
  end

  a_stall_quiet: assert property (@(posedge clk_in) disable iff (rst_in) !rdy_in |-> !cdb_valid)
  else
  begin
    errors++;
    $display("cdb_valid was high while rdy_in was low");
  end

  a_flush_empty: assert property (@(posedge clk_in) disable iff (rst_in)
    (flush_in && rdy_in) |=> (!cdb_valid && !rs_full))
  else
  begin
    errors++;
    $display("slice not empty right after a flush");
  end

  a_reset_empty: assert property (@(posedge clk_in) $fell(rst_in) |-> (!cdb_valid && !rs_full))
  else
  begin
    errors++;
    $display("slice not empty right after reset");
  end

  always @(posedge clk_in)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("timeout after %0d cycles, a tag never completed", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial
  begin
    int t;
    int p;
    int q;
    int prev;
    int span;
    clk_in      = 1'b0;
    rst_in      = 1'b1;
    rdy_in      = 1'b1;
    flush_in    = 1'b0;
    issue_valid = 1'b0;
    issue_op    = ALU_ADD;
    issue_src1  = '0;
    issue_src2  = '0;
    issue_dest  = '0;
    repeat (16) @(posedge clk_in);
    #0.5;
    rst_in = 1'b0;
    step();

    for (int i = 0; i < 20; i++)       // every op twice with independent operands
    begin
      t = next_free_tag();
      send_op(alu_op_e'(4'(i % 10)), -1, -1, $random(seed), $random(seed), t);
    end
    wait_drain();
    close_test(1, "independent");

    for (int c = 0; c < 3; c++)        // chains of five
    begin
      prev = -1;
      for (int i = 0; i < 5; i++)
      begin
        t = next_free_tag();
        send_op(random_op(), prev, -1, $random(seed), $random(seed), t);
        prev = t;
      end
    end
    p = next_free_tag();
    send_op(ALU_ADD, -1, -1, $random(seed), $random(seed), p);
    q = next_free_tag();
    send_op(ALU_XOR, -1, -1, $random(seed), $random(seed), q);
    t = next_free_tag();
    send_op(ALU_SUB, p, q, '0, '0, t);   // two producers feeding one consumer
    wait_drain();
    p = next_free_tag();
    send_op(ALU_SLL, -1, -1, $random(seed), $random(seed), p);
    while (!(cdb_valid && int'(cdb_tag) == p))
      step();
    t = next_free_tag();
    send_op(ALU_ADD, p, -1, '0, $random(seed), t);  // issue lands on the broadcast
    wait_drain();
    close_test(2, "dependency");

    p = next_free_tag();               // producer held back until the end
    for (int i = 0; i < `RS_DEPTH - 1; i++)
    begin
      t = next_free_tag();
      send_op(random_op(), p, -1, '0, $random(seed), t);
    end
    a_not_full_early: assert (!rs_full)
    else
    begin
      errors++;
      $display("rs_full rose with one entry still free");
    end
    send_op(ALU_OR, -1, -1, $random(seed), $random(seed), p);
    a_full: assert (rs_full)
    else
    begin
      errors++;
      $display("rs_full stayed low with every entry in use");
    end
    wait_drain();
    a_drained: assert (!rs_full)
    else
    begin
      errors++;
      $display("rs_full still high after the station drained");
    end
    close_test(3, "fill");

    prev = -1;
    for (int i = 0; i < 6; i++)
    begin
      t = next_free_tag();
      send_op(random_op(), (i > 1) ? prev : -1, -1, $random(seed), $random(seed), t);
      prev = t;
    end
    span   = 3 + ($unsigned($random(seed)) % 8);
    rdy_in = 1'b0;
    repeat (span) step();
    rdy_in = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      t = next_free_tag();
      send_op(random_op(), prev, -1, $random(seed), $random(seed), t);
      prev = t;
    end
    wait_drain();
    close_test(4, "stall");

    q = next_free_tag();               // never issued
    for (int i = 0; i < 3; i++)
    begin
      t = next_free_tag();
      send_op(ALU_OR, q, -1, '0, $random(seed), t);
    end
    for (int i = 0; i < 3; i++)
    begin
      t = next_free_tag();
      send_op(random_op(), -1, -1, $random(seed), $random(seed), t);
    end
    pulse_flush();
    repeat (6) step();
    for (int i = 0; i < 6; i++)
    begin
      t = next_free_tag();
      send_op(random_op(), -1, -1, $random(seed), $random(seed), t);
    end
    wait_drain();
    close_test(5, "flush");

    $display("tests %0d, broadcasts checked %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && checks > 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/exec_core.sv
/* out-of-order execution slice */
`timescale 1ns/10ps
`default_nettype none
`include "exec_macros.svh"

module exec_core import exec_pkg::*; (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  rdy_in,      // freeze everything while low
  input  logic                  flush_in,    // mispredict, drop in-flight work
  input  logic                  issue_valid,
  input  alu_op_e               issue_op,
  input  operand_t              issue_src1,
  input  operand_t              issue_src2,
  input  logic [`ROB_TAG_W-1:0] issue_dest,
  output logic                  rs_full,
  output logic                  cdb_valid,
  output logic [`ROB_TAG_W-1:0] cdb_tag,
  output logic [`XLEN-1:0]      cdb_value
);

  logic [`NUM_LANES-1:0] lane_busy;
  logic [`NUM_LANES-1:0] lane_req_valid;
  lane_req_t             lane_req [`NUM_LANES];

  exec_bus_if lane_bus [`NUM_LANES] ();   // lane to arbiter
  exec_bus_if cdb_bus ();                 // arbiter to station

  res_station u_rs (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .flush_in       (flush_in),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .issue_src1     (issue_src1),
    .issue_src2     (issue_src2),
    .issue_dest     (issue_dest),
    .lane_busy      (lane_busy),
    .rs_full        (rs_full),
    .lane_req_valid (lane_req_valid),
    .lane_req       (lane_req),
    .cdb            (cdb_bus)
  );

  for (genvar g = 0; g < `NUM_LANES; g++)
  begin : g_lane
    alu_lane u_lane (
      .clk_in    (clk_in),
      .rst_in    (rst_in),
      .rdy_in    (rdy_in),
      .flush_in  (flush_in),
      .req_valid (lane_req_valid[g]),
      .req       (lane_req[g]),
      .busy      (lane_busy[g]),
      .res       (lane_bus[g])
    );
  end

  cdb_arbiter u_arb (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .rdy_in   (rdy_in),
    .flush_in (flush_in),
    .lanes    (lane_bus),
    .cdb      (cdb_bus)
  );

  assign cdb_valid = cdb_bus.valid;
  assign cdb_tag   = cdb_bus.tag;
  assign cdb_value = cdb_bus.value;

endmodule

`default_nettype wire

//--- hdl/res_station.sv
/* reservation station */
`timescale 1ns/10ps
`default_nettype none
`include "exec_macros.svh"

module res_station import exec_pkg::*; (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  rdy_in,
  input  logic                  flush_in,
  input  logic                  issue_valid,
  input  alu_op_e               issue_op,
  input  operand_t              issue_src1,
  input  operand_t              issue_src2,
  input  logic [`ROB_TAG_W-1:0] issue_dest,
  input  logic [`NUM_LANES-1:0] lane_busy,    // lane holds an ungranted result
  output logic                  rs_full,
  output logic [`NUM_LANES-1:0] lane_req_valid,
  output lane_req_t             lane_req [`NUM_LANES],
  exec_bus_if.sink              cdb
);

  localparam int IDX_W = $clog2(`RS_DEPTH);

  rs_entry_t             ent_q [`RS_DEPTH];
  logic [`RS_DEPTH-1:0]  vld_q;
  logic [`RS_AGE_W-1:0]  age_cnt_q;               // stamp for next issue
  logic [`RS_DEPTH-1:0]  ent_rdy;                 // both operands ready
  logic [`RS_DEPTH-1:0]  picked;                  // sent to a lane this cycle
  logic [`NUM_LANES-1:0] pick_vld;
  logic [IDX_W-1:0]      pick_idx [`NUM_LANES];
  logic [IDX_W-1:0]      free_idx;
  logic                  issue_go;
  operand_t              iss_src1;                // issue operands after bypass
  operand_t              iss_src2;

  // capture a broadcast value for a waiting operand
  function automatic operand_t wake(operand_t opnd, logic bv, logic [`ROB_TAG_W-1:0] bt,
                                    logic [`XLEN-1:0] bval);
    operand_t o;
    o = opnd;
    if (!opnd.ready && bv && (opnd.tag == bt))
    begin
      o.value = bval;
      o.ready = 1'b1;
    end
    return o;
  endfunction

  // a issued before b, stamps compared modulo
  function automatic logic older(logic [`RS_AGE_W-1:0] a, logic [`RS_AGE_W-1:0] b);
    logic [`RS_AGE_W-1:0] diff;
    diff = a - b;
    return diff[`RS_AGE_W-1];
  endfunction

  assign cdb.grant = 1'b1;          // cdb never stalls
  assign rs_full   = &vld_q;
  assign issue_go  = issue_valid && rdy_in && !flush_in && !rs_full;
  assign iss_src1  = wake(issue_src1, cdb.valid, cdb.tag, cdb.value);  // same-cycle bypass
  assign iss_src2  = wake(issue_src2, cdb.valid, cdb.tag, cdb.value);

  always_comb
  begin
    free_idx = '0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--)
    begin
      if (!vld_q[i])
        free_idx = IDX_W'(i);       // lowest empty slot
      ent_rdy[i] = vld_q[i] && ent_q[i].src1.ready && ent_q[i].src2.ready;
    end
  end

  // lanes in order, each takes the oldest ready entry not yet taken
  always_comb
  begin
    logic [IDX_W-1:0] best;
    logic             found;
    picked   = '0;
    pick_vld = '0;
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      best  = '0;
      found = 1'b0;
      if (!lane_busy[l] && !lane_req_valid[l])   // pending request not consumed yet
      begin
        for (int i = 0; i < `RS_DEPTH; i++)
        begin
          if (ent_rdy[i] && !picked[i] && (!found || older(ent_q[i].age, ent_q[best].age)))
          begin
            best  = IDX_W'(i);
            found = 1'b1;
          end
        end
      end
      pick_vld[l] = found;
      pick_idx[l] = best;
      if (found)
        picked[best] = 1'b1;
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      vld_q          <= '0;
      age_cnt_q      <= '0;
      lane_req_valid <= '0;
    end
    else if (rdy_in)
    begin
      if (flush_in)
      begin
        vld_q          <= '0;       // drop everything in flight
        lane_req_valid <= '0;
      end
      else
      begin
        vld_q          <= (vld_q & ~picked) | (issue_go ? (`RS_DEPTH'(1) << free_idx) : '0);
        lane_req_valid <= pick_vld;  // one cycle start pulse
        if (issue_go)
          age_cnt_q <= age_cnt_q + 1'b1;
      end
    end
  end

  // entry payload and lane requests
  always_ff @(posedge clk_in)
  begin
    if (rdy_in)
    begin
      for (int i = 0; i < `RS_DEPTH; i++)
      begin
        ent_q[i].src1 <= wake(ent_q[i].src1, cdb.valid, cdb.tag, cdb.value);
        ent_q[i].src2 <= wake(ent_q[i].src2, cdb.valid, cdb.tag, cdb.value);
      end
      if (issue_go)
        ent_q[free_idx] <= '{op: issue_op, src1: iss_src1, src2: iss_src2,
                             dest: issue_dest, age: age_cnt_q};
      for (int l = 0; l < `NUM_LANES; l++)
        lane_req[l] <= '{op: ent_q[pick_idx[l]].op, val1: ent_q[pick_idx[l]].src1.value,
                         val2: ent_q[pick_idx[l]].src2.value, dest: ent_q[pick_idx[l]].dest};
    end
  end

  a_no_issue_full: assert property (@(posedge clk_in) disable iff (rst_in)
    (issue_valid && rdy_in) |-> !rs_full);

  // tags are unique in flight, so two lanes never carry the same one
  for (genvar a = 0; a < `NUM_LANES; a++)
  begin : g_uniq_a
    for (genvar b = a + 1; b < `NUM_LANES; b++)
    begin : g_uniq_b
      a_one_lane: assert property (@(posedge clk_in) disable iff (rst_in)
        (lane_req_valid[a] && lane_req_valid[b]) |-> (lane_req[a].dest != lane_req[b].dest));
    end
  end

endmodule

`default_nettype wire

//--- hdl/cdb_arbiter.sv
/* round-robin cdb arbiter */
`timescale 1ns/10ps
`default_nettype none
`include "exec_macros.svh"

module cdb_arbiter import exec_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic       rdy_in,
  input  logic       flush_in,
  exec_bus_if.sink   lanes [`NUM_LANES],
  exec_bus_if.source cdb
);

  localparam int N  = `NUM_LANES;
  localparam int LW = $clog2(N);

  logic [N-1:0]  lane_vld;
  cdb_result_t   lane_res [N];
  logic [N-1:0]  gnt;
  logic [LW-1:0] ptr_q;          // highest priority lane
  logic [LW-1:0] win_idx;
  logic          win;

  // flatten the interface array
  for (genvar g = 0; g < N; g++)
  begin : g_lane
    assign lane_vld[g]    = lanes[g].valid;
    assign lane_res[g]    = '{tag: lanes[g].tag, value: lanes[g].value};
    assign lanes[g].grant = gnt[g];
  end

  always_comb
  begin
    int idx;
    win     = 1'b0;
    win_idx = '0;
    for (int k = 0; k < N; k++)
    begin
      idx = int'(ptr_q) + k;
      if (idx >= N)
        idx = idx - N;           // wrap around
      if (!win && lane_vld[idx])
      begin
        win     = 1'b1;
        win_idx = LW'(idx);
      end
    end
    win = win && rdy_in && !flush_in;   // no broadcast while stalled or flushing
  end

  assign gnt       = win ? (N'(1) << win_idx) : '0;
  assign cdb.valid = win;
  assign cdb.tag   = lane_res[win_idx].tag;
  assign cdb.value = lane_res[win_idx].value;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
      ptr_q <= '0;
    else if (rdy_in)
    begin
      if (flush_in)
        ptr_q <= '0;
      else if (win)
        ptr_q <= (win_idx == LW'(N - 1)) ? '0 : win_idx + 1'b1;  // move past winner
    end
  end

  a_one_grant: assert property (@(posedge clk_in) disable iff (rst_in)
    $onehot0(gnt) && ((gnt & ~lane_vld) == '0));

endmodule

`default_nettype wire

//--- hdl/alu_lane.sv
/* integer alu lane */
`timescale 1ns/10ps
`default_nettype none
`include "exec_macros.svh"

module alu_lane import exec_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic       rdy_in,
  input  logic       flush_in,
  input  logic       req_valid,    // start pulse from the station
  input  lane_req_t  req,
  output logic       busy,
  exec_bus_if.source res
);

  logic             valid_q;
  cdb_result_t      held_q;       // result waiting for grant
  logic [`XLEN-1:0] result;
  logic [4:0]       shamt;

  assign shamt = req.val2[4:0];

  always_comb
  begin
    case (req.op)
      ALU_ADD:  result = req.val1 + req.val2;
      ALU_SUB:  result = req.val1 - req.val2;
      ALU_AND:  result = req.val1 & req.val2;
      ALU_OR:   result = req.val1 | req.val2;
      ALU_XOR:  result = req.val1 ^ req.val2;
      ALU_SLL:  result = req.val1 << shamt;
      ALU_SRL:  result = req.val1 >> shamt;
      ALU_SRA:  result = $unsigned($signed(req.val1) >>> shamt);
      ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(req.val1) < $signed(req.val2)};
      ALU_SLTU: result = {{(`XLEN-1){1'b0}}, req.val1 < req.val2};
      default:  result = '0;
    endcase
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
      valid_q <= 1'b0;
    else if (rdy_in)
    begin
      if (flush_in)
        valid_q <= 1'b0;
      else if (req_valid)
        valid_q <= 1'b1;
      else if (res.grant)
        valid_q <= 1'b0;          // taken by the cdb
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_in && req_valid)
      held_q <= '{tag: req.dest, value: result};
  end

  assign res.valid = valid_q;
  assign res.tag   = held_q.tag;
  assign res.value = held_q.value;
  assign busy      = valid_q;     // station stops feeding while held

  a_no_req_busy: assert property (@(posedge clk_in) disable iff (rst_in)
    (req_valid && rdy_in) |-> !busy);

endmodule

`default_nettype wire

//--- hdl/exec_bus_if.sv
/* tagged result bus */
`timescale 1ns/10ps
`default_nettype none
`include "exec_macros.svh"

// one tagged result, source holds it while valid and not granted
interface exec_bus_if;
  logic                  valid;   // result present
  logic [`ROB_TAG_W-1:0] tag;     // rob entry it completes
  logic [`XLEN-1:0]      value;
  logic                  grant;   // sink takes it this cycle

  modport source (
    output valid,
    output tag,
    output value,
    input  grant
  );

  modport sink (
    input  valid,
    input  tag,
    input  value,
    output grant
  );

endinterface

`default_nettype wire

//--- hdl/exec_pkg.sv
/* execution slice types */
`default_nettype none
`include "exec_macros.svh"

package exec_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // value valid when ready, else waiting on tag
  typedef struct packed {
    logic [`XLEN-1:0]      value;
    logic [`ROB_TAG_W-1:0] tag;
    logic                  ready;
  } operand_t;

  typedef struct packed {
    alu_op_e               op;
    operand_t              src1;
    operand_t              src2;
    logic [`ROB_TAG_W-1:0] dest;
    logic [`RS_AGE_W-1:0]  age;   // issue order stamp
  } rs_entry_t;

  // station to lane, operands already resolved
  typedef struct packed {
    alu_op_e               op;
    logic [`XLEN-1:0]      val1;
    logic [`XLEN-1:0]      val2;
    logic [`ROB_TAG_W-1:0] dest;
  } lane_req_t;

  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    logic [`XLEN-1:0]      value;
  } cdb_result_t;

endpackage

`default_nettype wire

//--- hdl/exec_macros.svh
/* execution slice widths and counts */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// reorder buffer tag width
`define ROB_TAG_W 4
// integer datapath width
`define XLEN 32
// reservation station entries
`define RS_DEPTH 8
// alu lanes, 2 to 4 supported
`define NUM_LANES 3
// issue age stamp width, wraps, compared modulo
`define RS_AGE_W 8

`endif
